// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                request0,
  input  logic                                request1,
  input  logic [icache_pkg::ADDR_BITS-1:0]    request_addr0,
  input  logic [icache_pkg::ADDR_BITS-1:0]    request_addr1,
  output logic                                accept0,
  output logic                                accept1,
  output icache_pkg::bus_command_e            mem_command,
  output logic [icache_pkg::ADDR_BITS-1:0]    mem_addr,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  output logic                                record,
  output logic [icache_pkg::ADDR_BITS-1:0]    record_addr,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] record_tag
);

  logic favor1; // port 1 wins a tie
  logic grant0;
  logic grant1;
  logic accepted;

  assign grant1 = request1 && (!request0 || favor1);
  assign grant0 = request0 && !grant1;

  assign mem_command = (grant0 || grant1) ? icache_pkg::BUS_LOAD : icache_pkg::BUS_NONE;
  assign mem_addr    = grant1 ? request_addr1 : request_addr0;

  // zero response means refused, the port simply keeps requesting
  assign accepted = (mem_command == icache_pkg::BUS_LOAD) && (mem_response != '0);

  assign accept0 = accepted && grant0;
  assign accept1 = accepted && grant1;

  assign record      = accepted;
  assign record_addr = mem_addr;
  assign record_tag  = mem_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      favor1 <= 1'b0;
    end else if (accepted) begin
      favor1 <= grant0; // other port goes first next time
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
icache_pkg.sv
icache_tag_data.sv
icache_fetch_port.sv
bus_arbiter.sv
fill_queue.sv
icache_top.sv
icache_assert.sv
tb_imem.sv
tb_icache.sv

// File: fill_queue.sv
`default_nettype none

module fill_queue #(
  parameter int FILL_DEPTH   = 2,
  parameter int NUM_SET_BITS = 5
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                record,
  input  logic [icache_pkg::ADDR_BITS-1:0]    record_addr,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] record_tag,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
  input  logic [icache_pkg::DATA_BITS-1:0]    mem_data,
  output logic                                wr_en,
  output logic [icache_pkg::ADDR_BITS-1:0]    wr_addr,
  output logic [icache_pkg::DATA_BITS-1:0]    wr_data
);

  localparam int NUM_TAGS   = 2 ** icache_pkg::MEM_TAG_BITS;
  localparam int PTR_BITS   = (FILL_DEPTH > 1) ? $clog2(FILL_DEPTH) : 1;
  localparam int COUNT_BITS = $clog2(FILL_DEPTH + 1);

  logic [icache_pkg::ADDR_BITS-1:0] tag_table [NUM_TAGS]; // address per outstanding tag

  logic [icache_pkg::ADDR_BITS-1:0] fifo_addr [FILL_DEPTH];
  logic [icache_pkg::DATA_BITS-1:0] fifo_data [FILL_DEPTH];
  logic [PTR_BITS-1:0]              wr_ptr;
  logic [PTR_BITS-1:0]              rd_ptr;
  logic [COUNT_BITS-1:0]            fill_count;

  logic push;
  logic pop;

  assign push = mem_tag != '0;
  assign pop  = fill_count != '0;

  assign wr_en   = pop;
  assign wr_addr = fifo_addr[rd_ptr];
  assign wr_data = fifo_data[rd_ptr];

  always_ff @(posedge clock) begin
    if (record) begin
      tag_table[record_tag] <= record_addr;
    end
    if (push) begin
      fifo_addr[wr_ptr] <= tag_table[mem_tag];
      fifo_data[wr_ptr] <= mem_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(FILL_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(FILL_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count; // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: icache_assert.sv
`default_nettype none

module icache_assert #(
  parameter int DEPTH = 2
) (
  input logic                           clock,
  input logic                           reset,
  input logic                           push,
  input logic                           pop,
  input logic [$clog2(DEPTH+1)-1:0]     fill_count,
  input logic                           accept0,
  input logic                           accept1,
  input icache_pkg::bus_command_e       mem_command
);

  timeunit 1ns;
  timeprecision 100ps;

  // memory cannot be stalled, so a full queue must drain in the same cycle
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    !(push && !pop && (fill_count == ($clog2(DEPTH+1))'(DEPTH))))
    else $error("fill queue overflow");

  a_accept_needs_load: assert property (@(posedge clock) disable iff (reset)
    (accept0 || accept1) |-> (mem_command == icache_pkg::BUS_LOAD))
    else $error("accept without a load command");

  a_one_accept: assert property (@(posedge clock) disable iff (reset)
    !(accept0 && accept1))
    else $error("both ports accepted at once");

endmodule

bind fill_queue icache_assert #(.DEPTH(FILL_DEPTH)) u_queue_assert (
  .clock       (clock),
  .reset       (reset),
  .push        (push),
  .pop         (pop),
  .fill_count  (fill_count),
  .accept0     (1'b0),
  .accept1     (1'b0),
  .mem_command (icache_pkg::BUS_NONE)
);

bind bus_arbiter icache_assert #(.DEPTH(2)) u_arbiter_assert (
  .clock       (clock),
  .reset       (reset),
  .push        (1'b0),
  .pop         (1'b0),
  .fill_count  (2'd0),
  .accept0     (accept0),
  .accept1     (accept1),
  .mem_command (mem_command)
);

`default_nettype wire

// File: icache_fetch_port.sv
`default_nettype none

module icache_fetch_port (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [icache_pkg::ADDR_BITS-1:0] fetch_addr,
  input  logic                             hit,
  input  logic [icache_pkg::DATA_BITS-1:0] line_data,
  output logic [icache_pkg::DATA_BITS-1:0] fetch_data,
  output logic                             fetch_valid,
  output logic                             request,
  output logic [icache_pkg::ADDR_BITS-1:0] request_addr,
  input  logic                             accept
);

  icache_pkg::port_state_e state;
  icache_pkg::port_state_e state_next;

  logic [icache_pkg::ADDR_BITS-1:0] fetch_line;
  logic [icache_pkg::ADDR_BITS-1:0] last_addr; // line seen on the previous cycle
  logic                             addr_changed;

  assign fetch_line   = icache_pkg::line_addr(fetch_addr);
  assign addr_changed = fetch_line != last_addr;

  // hit path is purely combinational
  assign fetch_valid = hit;
  assign fetch_data  = line_data;

  // a changed address or a late fill cancels the request at once
  assign request      = (state == icache_pkg::PORT_REQUEST) && !addr_changed && !hit;
  assign request_addr = last_addr;

  always_comb begin
    state_next = state;
    case (state)
      icache_pkg::PORT_IDLE: begin
        if (!hit) begin
          state_next = icache_pkg::PORT_REQUEST; // miss
        end
      end
      icache_pkg::PORT_REQUEST: begin
        if (hit || addr_changed) begin
          state_next = icache_pkg::PORT_IDLE;
        end else if (accept) begin
          state_next = icache_pkg::PORT_WAIT;
        end
      end
      icache_pkg::PORT_WAIT: begin
        // fill still lands even if the port leaves early
        if (hit || addr_changed) begin
          state_next = icache_pkg::PORT_IDLE;
        end
      end
      default: begin
        state_next = icache_pkg::PORT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= icache_pkg::PORT_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    last_addr <= fetch_line;
  end

endmodule

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

  localparam int ADDR_BITS    = 32;
  localparam int DATA_BITS    = 64;
  localparam int MEM_TAG_BITS = 4;
  localparam int OFFSET_BITS  = 3; // byte within the 8-byte line

  typedef enum logic [1:0] {
    BUS_NONE     = 2'd0,
    BUS_LOAD     = 2'd1,
    BUS_STORE    = 2'd2, // width only
    BUS_RESERVED = 2'd3  // width only
  } bus_command_e;

  typedef enum logic [1:0] {
    PORT_IDLE    = 2'd0,
    PORT_REQUEST = 2'd1,
    PORT_WAIT    = 2'd2
  } port_state_e;

  // clear the byte offset
  function automatic logic [ADDR_BITS-1:0] line_addr(input logic [ADDR_BITS-1:0] addr);
    return {addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

  // set index, right aligned; caller truncates to its own width
  function automatic logic [ADDR_BITS-1:0] addr_index(input logic [ADDR_BITS-1:0] addr,
                                                      input int unsigned set_bits);
    logic [ADDR_BITS-1:0] mask;
    mask = {ADDR_BITS{1'b1}} >> (ADDR_BITS - set_bits);
    return (addr >> OFFSET_BITS) & mask;
  endfunction

  // everything above index and offset
  function automatic logic [ADDR_BITS-1:0] addr_tag(input logic [ADDR_BITS-1:0] addr,
                                                    input int unsigned set_bits);
    return addr >> (OFFSET_BITS + set_bits);
  endfunction

endpackage

`default_nettype wire

// File: icache_tag_data.sv
`default_nettype none

module icache_tag_data #(
  parameter int NUM_SET_BITS = 5
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [icache_pkg::ADDR_BITS-1:0] rd_addr0,
  input  logic [icache_pkg::ADDR_BITS-1:0] rd_addr1,
  output logic [icache_pkg::DATA_BITS-1:0] rd_data0,
  output logic [icache_pkg::DATA_BITS-1:0] rd_data1,
  output logic                             rd_hit0,
  output logic                             rd_hit1,
  input  logic                             wr_en,
  input  logic [icache_pkg::ADDR_BITS-1:0] wr_addr,
  input  logic [icache_pkg::DATA_BITS-1:0] wr_data
);

  localparam int NUM_SETS = 2 ** NUM_SET_BITS;
  localparam int TAG_BITS = icache_pkg::ADDR_BITS - NUM_SET_BITS - icache_pkg::OFFSET_BITS;

  logic [TAG_BITS-1:0]              tag_mem  [NUM_SETS];
  logic [icache_pkg::DATA_BITS-1:0] data_mem [NUM_SETS];
  logic [NUM_SETS-1:0]              valid;

  logic [NUM_SET_BITS-1:0] wr_index;
  logic [TAG_BITS-1:0]     wr_tag;

  // both read ports share one lookup body
  logic [icache_pkg::ADDR_BITS-1:0] rd_addr [2];
  logic [icache_pkg::DATA_BITS-1:0] rd_data [2];
  logic                             rd_hit  [2];

  assign rd_addr[0] = rd_addr0;
  assign rd_addr[1] = rd_addr1;
  assign rd_data0   = rd_data[0];
  assign rd_data1   = rd_data[1];
  assign rd_hit0    = rd_hit[0];
  assign rd_hit1    = rd_hit[1];

  for (genvar i = 0; i < 2; i++) begin : g_read
    logic [NUM_SET_BITS-1:0] rd_index;
    logic [TAG_BITS-1:0]     rd_tag;

    assign rd_index   = NUM_SET_BITS'(icache_pkg::addr_index(rd_addr[i], NUM_SET_BITS));
    assign rd_tag     = TAG_BITS'(icache_pkg::addr_tag(rd_addr[i], NUM_SET_BITS));
    assign rd_hit[i]  = valid[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign rd_data[i] = data_mem[rd_index];
  end

  assign wr_index = NUM_SET_BITS'(icache_pkg::addr_index(wr_addr, NUM_SET_BITS));
  assign wr_tag   = TAG_BITS'(icache_pkg::addr_tag(wr_addr, NUM_SET_BITS));

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_mem[wr_index]  <= wr_tag; // same-index fill displaces the old line
      data_mem[wr_index] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: icache_top.sv
`default_nettype none

module icache_top #(
  parameter int NUM_SET_BITS = 5,
  parameter int FILL_DEPTH   = 2
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [icache_pkg::ADDR_BITS-1:0]    fetch_addr0,
  output logic [icache_pkg::DATA_BITS-1:0]    fetch_data0,
  output logic                                fetch_valid0,
  input  logic [icache_pkg::ADDR_BITS-1:0]    fetch_addr1,
  output logic [icache_pkg::DATA_BITS-1:0]    fetch_data1,
  output logic                                fetch_valid1,
  output icache_pkg::bus_command_e            mem_command,
  output logic [icache_pkg::ADDR_BITS-1:0]    mem_addr,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  input  logic [icache_pkg::DATA_BITS-1:0]    mem_data,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag
);

  logic [icache_pkg::DATA_BITS-1:0]    line_data0;
  logic [icache_pkg::DATA_BITS-1:0]    line_data1;
  logic                                hit0;
  logic                                hit1;
  logic                                request0;
  logic                                request1;
  logic [icache_pkg::ADDR_BITS-1:0]    request_addr0;
  logic [icache_pkg::ADDR_BITS-1:0]    request_addr1;
  logic                                accept0;
  logic                                accept1;
  logic                                record;
  logic [icache_pkg::ADDR_BITS-1:0]    record_addr;
  logic [icache_pkg::MEM_TAG_BITS-1:0] record_tag;
  logic                                wr_en;
  logic [icache_pkg::ADDR_BITS-1:0]    wr_addr;
  logic [icache_pkg::DATA_BITS-1:0]    wr_data;

  icache_tag_data #(
    .NUM_SET_BITS (NUM_SET_BITS)
  ) u_tag_data (
    .clock    (clock),
    .reset    (reset),
    .rd_addr0 (fetch_addr0),
    .rd_addr1 (fetch_addr1),
    .rd_data0 (line_data0),
    .rd_data1 (line_data1),
    .rd_hit0  (hit0),
    .rd_hit1  (hit1),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  icache_fetch_port u_port0 (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr0),
    .hit          (hit0),
    .line_data    (line_data0),
    .fetch_data   (fetch_data0),
    .fetch_valid  (fetch_valid0),
    .request      (request0),
    .request_addr (request_addr0),
    .accept       (accept0)
  );

  icache_fetch_port u_port1 (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr1),
    .hit          (hit1),
    .line_data    (line_data1),
    .fetch_data   (fetch_data1),
    .fetch_valid  (fetch_valid1),
    .request      (request1),
    .request_addr (request_addr1),
    .accept       (accept1)
  );

  bus_arbiter u_arbiter (
    .clock         (clock),
    .reset         (reset),
    .request0      (request0),
    .request1      (request1),
    .request_addr0 (request_addr0),
    .request_addr1 (request_addr1),
    .accept0       (accept0),
    .accept1       (accept1),
    .mem_command   (mem_command),
    .mem_addr      (mem_addr),
    .mem_response  (mem_response),
    .record        (record),
    .record_addr   (record_addr),
    .record_tag    (record_tag)
  );

  fill_queue #(
    .FILL_DEPTH   (FILL_DEPTH),
    .NUM_SET_BITS (NUM_SET_BITS)
  ) u_fill_queue (
    .clock       (clock),
    .reset       (reset),
    .record      (record),
    .record_addr (record_addr),
    .record_tag  (record_tag),
    .mem_tag     (mem_tag),
    .mem_data    (mem_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_icache -o sim_icache &&
./obj_dir/sim_icache | grep -F "*** PASSED ***" && exit 0 || exit 1

// File: tb_icache.sv
`default_nettype none

module tb_icache;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_SET_BITS     = 5;
  localparam int FILL_DEPTH       = 2;
  localparam int NUM_SETS         = 2 ** NUM_SET_BITS;
  localparam int TAG_BITS         = 32 - NUM_SET_BITS - 3;
  localparam int POOL_SIZE        = 48;
  localparam int NUM_FETCHES      = 4000;
  localparam int CYCLES_PER_FETCH = 40;
  localparam int MAX_WAIT         = 200;
  localparam logic [31:0] LINE_KEY = 32'h5a3c96e1;

  logic clock = 1'b0;
  logic reset;
  logic [31:0] fetch_addr0;
  logic [31:0] fetch_addr1;
  logic [63:0] fetch_data0;
  logic [63:0] fetch_data1;
  logic        fetch_valid0;
  logic        fetch_valid1;
  icache_pkg::bus_command_e mem_command;
  logic [31:0] mem_addr;
  logic [3:0]  mem_response;
  logic [63:0] mem_data;
  logic [3:0]  mem_tag;

  logic [31:0]         pool [POOL_SIZE];
  logic [31:0]         cur_addr [2];
  logic                done [2];
  int                  wait_cycles [2];
  logic                model_valid [NUM_SETS]; // what the cache should hold
  logic [TAG_BITS-1:0] model_tag [NUM_SETS];
  logic                fill_due [NUM_SETS]; // returned line not yet written
  logic [TAG_BITS-1:0] fill_tag [NUM_SETS];
  int                  pending_until [NUM_SETS];
  logic [31:0]         tag_addr [16];
  logic                retry_due;
  logic [31:0]         refused_line;
  logic                held [2];
  int cycle;
  int fetch_count;
  int refusals;
  int accepts [2];
  int completions [2];
  logic running;

  always #5 clock = ~clock;

  icache_top #(
    .NUM_SET_BITS (NUM_SET_BITS),
    .FILL_DEPTH   (FILL_DEPTH)
  ) u_icache_top (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr0  (fetch_addr0),
    .fetch_data0  (fetch_data0),
    .fetch_valid0 (fetch_valid0),
    .fetch_addr1  (fetch_addr1),
    .fetch_data1  (fetch_data1),
    .fetch_valid1 (fetch_valid1),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  tb_imem #(.LINE_KEY(LINE_KEY)) u_mem (
    .clock        (clock),
    .reset        (reset),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  function automatic logic [63:0] expected_line(input logic [31:0] addr);
    logic [31:0] x;
    x = {addr[31:3], 3'b000} ^ LINE_KEY;
    return {x, ~x};
  endfunction

  function automatic int set_of(input logic [31:0] addr);
    return int'(addr[NUM_SET_BITS+2:3]);
  endfunction

  function automatic logic [TAG_BITS-1:0] tag_of(input logic [31:0] addr);
    return addr[31:NUM_SET_BITS+3];
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_command(input string name, input icache_pkg::bus_command_e got,
                               input icache_pkg::bus_command_e exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic pick_addr(input int p);
    cur_addr[p] = pool[$urandom_range(POOL_SIZE - 1)] | 32'($urandom_range(7));
    done[p] = 1'b0;
    wait_cycles[p] = 0;
    fetch_count++;
  endtask

  task automatic settle_set(input int s);
    if (fill_due[s] && cycle > pending_until[s]) begin
      model_valid[s] = 1'b1; // last returned line is written by now
      model_tag[s]   = fill_tag[s];
      fill_due[s]    = 1'b0;
    end
  endtask

  task automatic observe_port(input int p, input logic valid, input logic [63:0] data);
    int s;
    s = set_of(cur_addr[p]);
    settle_set(s);
    if (model_valid[s] && model_tag[s] == tag_of(cur_addr[p])) begin
      check_flag($sformatf("fetch_valid%0d", p), valid, 1'b1); // line still resident
    end
    if (valid) begin
      check_data($sformatf("fetch_data%0d", p), data, expected_line(cur_addr[p]));
      if (!done[p]) completions[p]++;
      done[p] = 1'b1;
    end else begin
      wait_cycles[p]++;
      if (wait_cycles[p] > MAX_WAIT) begin
        report_failure($sformatf("port %0d never got its line", p));
      end
    end
  endtask

  // all checks mid cycle, inputs are stable here
  always @(negedge clock) begin
    int s;
    logic still_held;
    logic [31:0] exp_line;
    if (running) begin
      cycle++;
      if (retry_due) begin
        still_held = 1'b1;
        if (held[0] && (cur_addr[0][31:3] != refused_line[31:3] || fetch_valid0)) begin
          still_held = 1'b0;
        end
        if (held[1] && (cur_addr[1][31:3] != refused_line[31:3] || fetch_valid1)) begin
          still_held = 1'b0;
        end
        if (still_held) begin
          check_command("mem_command", mem_command, icache_pkg::BUS_LOAD); // retry
        end
      end
      retry_due = 1'b0;
      if (mem_command == icache_pkg::BUS_LOAD) begin
        exp_line = {cur_addr[0][31:3], 3'b000};
        if (mem_addr[31:3] == cur_addr[1][31:3]) begin
          exp_line = {cur_addr[1][31:3], 3'b000};
        end
        check_addr("mem_addr", mem_addr, exp_line); // a port's own line, aligned
        if (mem_response == 4'd0) begin
          refusals++;
          retry_due    = 1'b1;
          refused_line = mem_addr;
          held[0]      = mem_addr[31:3] == cur_addr[0][31:3];
          held[1]      = mem_addr[31:3] == cur_addr[1][31:3];
        end else begin
          tag_addr[mem_response] = mem_addr;
          if (mem_addr[31:3] == cur_addr[0][31:3]) accepts[0]++;
          else if (mem_addr[31:3] == cur_addr[1][31:3]) accepts[1]++;
        end
        s = set_of(mem_addr);
        settle_set(s);
        if (model_valid[s] && model_tag[s] == tag_of(mem_addr)) begin
          report_failure("a load went out for a line that is still cached");
        end
      end
      if (mem_tag != 4'd0) begin
        s = set_of(tag_addr[mem_tag]); // fill may displace this set
        model_valid[s]   = 1'b0;
        fill_due[s]      = 1'b1;
        fill_tag[s]      = tag_of(tag_addr[mem_tag]);
        pending_until[s] = cycle + FILL_DEPTH + 2;
      end
      observe_port(0, fetch_valid0, fetch_data0);
      observe_port(1, fetch_valid1, fetch_data1);
    end
  end

  initial begin
    #(NUM_FETCHES * CYCLES_PER_FETCH * 10);
    report_failure("watchdog timeout, the fetches did not finish in time");
  end

  initial begin
    void'($urandom(32'h07b2c096));
    reset = 1'b1;
    running = 1'b0;
    cycle = 0;
    fetch_count = 0;
    refusals = 0;
    retry_due = 1'b0;
    refused_line = '0;
    for (int p = 0; p < 2; p++) begin
      accepts[p] = 0;
      completions[p] = 0;
      held[p] = 1'b0;
    end
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = {$urandom()} & 32'hffff_fff8;
    end
    for (int i = 0; i < NUM_SETS; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i] = '0;
      fill_due[i] = 1'b0;
      fill_tag[i] = '0;
      pending_until[i] = 0;
    end
    for (int i = 0; i < 16; i++) tag_addr[i] = '0;
    pick_addr(0);
    pick_addr(1);
    fetch_addr0 = cur_addr[0];
    fetch_addr1 = cur_addr[1];
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    check_command("mem_command", mem_command, icache_pkg::BUS_NONE);
    check_flag("fetch_valid0", fetch_valid0, 1'b0);
    check_flag("fetch_valid1", fetch_valid1, 1'b0);
    @(posedge clock);
    #1 running = 1'b1;
    while (fetch_count < NUM_FETCHES) begin
      @(posedge clock);
      #1;
      for (int p = 0; p < 2; p++) begin
        if (done[p] || $urandom_range(7) == 0) pick_addr(p); // 1 in 8 abandons early
      end
      fetch_addr0 = cur_addr[0];
      fetch_addr1 = cur_addr[1];
    end
    @(negedge clock);
    if (refusals == 0) begin
      report_failure("memory never refused a load");
    end else if (accepts[0] == 0 || accepts[1] == 0) begin
      report_failure("a port never got a load accepted");
    end else if (completions[0] == 0 || completions[1] == 0) begin
      report_failure("a port never completed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb_imem.sv
`default_nettype none

module tb_imem #(
  parameter logic [31:0] LINE_KEY = 32'h5a3c96e1
) (
  input  logic                                clock,
  input  logic                                reset,
  input  icache_pkg::bus_command_e            mem_command,
  input  logic [icache_pkg::ADDR_BITS-1:0]    mem_addr,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  output logic [icache_pkg::DATA_BITS-1:0]    mem_data,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag
);

  timeunit 1ns;
  timeprecision 100ps;

  logic        refuse;
  logic        took;
  logic [3:0]  next_tag;
  int          cycle;
  logic [3:0]  slot_tag [64]; // return schedule, one slot per cycle
  logic [31:0] slot_addr [64];

  function automatic logic [63:0] line_word(input logic [31:0] addr);
    logic [31:0] x;
    x = {addr[31:3], 3'b000} ^ LINE_KEY;
    return {x, ~x};
  endfunction

  assign mem_response = (!reset && !refuse && mem_command == icache_pkg::BUS_LOAD) ?
                        next_tag : 4'd0;

  initial begin
    refuse   = 1'b0;
    took     = 1'b0;
    next_tag = 4'd1;
    cycle    = 0;
    mem_data = '0;
    mem_tag  = '0;
    for (int i = 0; i < 64; i++) begin
      slot_tag[i]  = '0;
      slot_addr[i] = '0;
    end
  end

  // accepted load seen mid cycle, data comes back 2 to 8 cycles later
  always @(negedge clock) begin
    int d;
    d = 2 + int'($urandom_range(6));
    if (mem_response != 4'd0) begin
      while (slot_tag[(cycle + d) % 64] != 4'd0) begin
        d++; // one return per cycle
      end
      slot_tag[(cycle + d) % 64]  = mem_response;
      slot_addr[(cycle + d) % 64] = mem_addr;
      took = 1'b1;
    end
  end

  always @(posedge clock) begin
    #1;
    cycle++;
    mem_tag  = slot_tag[cycle % 64];
    mem_data = (slot_tag[cycle % 64] != 4'd0) ? line_word(slot_addr[cycle % 64]) : '0;
    slot_tag[cycle % 64] = 4'd0;
    refuse = ($urandom_range(3) == 0);
    if (took) begin
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      took     = 1'b0;
    end
  end

endmodule

`default_nettype wire
